// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// geometry of the cache, the address slicing depends on these values
	localparam int s_offset = 5; // byte offset within a line
	localparam int s_index  = 3;
	localparam int s_tag    = 24; // address bits above index and offset
	localparam int num_sets = 8;

	localparam int s_mask    = 2**s_offset; // bytes per line
	localparam int s_line    = 8*s_mask;
	localparam int num_words = s_mask/4; // 32-bit lanes per line

	typedef logic [31:0]        word_t;
	typedef logic [s_line-1:0]  line_t;
	typedef logic [s_mask-1:0]  line_mask_t;
	typedef logic [s_tag-1:0]   tag_t;
	typedef logic [s_index-1:0] index_t;

	typedef enum logic [1:0] {
		s_compare,   // tag check and hit response
		s_writeback, // dirty victim goes out to memory
		s_fill,
		s_replay     // fill line is written, the request is retried
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: common/dcache_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dcache_ctrl_if;

	logic       hit;
	logic       way0_hit;
	logic       lru_way;      // way to evict from the stage-2 set
	logic       victim_dirty;
	logic       pipe_read;
	logic       pipe_write;

	logic       load_pipe;
	logic [1:0] load_data;    // one bit per way
	logic [1:0] load_tag;
	logic       set_valid;
	logic [1:0] set_dirty;
	logic [1:0] clear_dirty;
	logic       load_lru;
	logic       latch_rdata;
	logic       use_latched;
	logic       wb_addr;

	modport dp (output hit, way0_hit, lru_way, victim_dirty, pipe_read, pipe_write,
		input load_pipe, load_data, load_tag, set_valid, set_dirty, clear_dirty,
		load_lru, latch_rdata, use_latched, wb_addr);

	modport ctrl (input hit, way0_hit, lru_way, victim_dirty,
		output load_pipe, load_data, load_tag, set_valid, set_dirty, clear_dirty,
		load_lru, latch_rdata, use_latched, wb_addr);

	modport prop (input hit, way0_hit, lru_way, victim_dirty, pipe_read, pipe_write,
		load_pipe, load_data, load_tag, set_valid, set_dirty, clear_dirty,
		load_lru, latch_rdata, use_latched, wb_addr);

endinterface

`default_nettype wire

// File: dcache/dcache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_data_array (
	input  logic                   clk,
	input  dcache_pkg::line_mask_t write_en,
	input  dcache_pkg::index_t     rindex,
	input  dcache_pkg::index_t     windex,
	input  logic                   read,
	input  dcache_pkg::line_t      datain,
	output dcache_pkg::line_t      dataout
);

	dcache_pkg::line_t  lines [dcache_pkg::num_sets];
	dcache_pkg::index_t out_index; // set whose line sits in dataout
	dcache_pkg::index_t sel_index;
	dcache_pkg::line_t  next_out;

	assign sel_index = read ? rindex : out_index; // a stalled read keeps looking at its own set

	always_comb begin
		next_out = lines[sel_index];
		for (int i = 0; i < dcache_pkg::s_mask; i++) begin
			if (write_en[i] && windex == sel_index) begin
				next_out[8*i +: 8] = datain[8*i +: 8]; // bytes written this cycle show up at once
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < dcache_pkg::s_mask; i++) begin
			if (write_en[i]) begin
				lines[windex][8*i +: 8] <= datain[8*i +: 8];
			end
		end
		out_index <= sel_index;
		dataout   <= next_out;
	end

endmodule

`default_nettype wire

// File: dcache/dcache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_array (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               read,
	input  dcache_pkg::index_t rindex,
	input  dcache_pkg::index_t windex,
	input  logic               load_tag,
	input  logic               set_valid,
	input  logic               set_dirty,
	input  logic               clear_dirty,
	input  dcache_pkg::tag_t   tag_in,
	output dcache_pkg::tag_t   tag_out,
	output logic               valid_out,
	output logic               dirty_out
);

	dcache_pkg::tag_t                tags [dcache_pkg::num_sets];
	logic [dcache_pkg::num_sets-1:0] valid;
	logic [dcache_pkg::num_sets-1:0] dirty;
	dcache_pkg::index_t              out_index;
	dcache_pkg::index_t              sel_index;
	logic                            same_set;

	assign sel_index = read ? rindex : out_index;
	assign same_set  = windex == sel_index; // forward updates into the output register

	always_ff @(posedge clk) begin
		if (load_tag) begin
			tags[windex] <= tag_in;
		end
		out_index <= sel_index;
		tag_out   <= (load_tag && same_set) ? tag_in : tags[sel_index];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid     <= '0;
			dirty     <= '0;
			valid_out <= 1'b0;
			dirty_out <= 1'b0;
		end else begin
			if (set_valid) begin
				valid[windex] <= 1'b1;
			end
			if (set_dirty) begin
				dirty[windex] <= 1'b1;
			end else if (clear_dirty) begin
				dirty[windex] <= 1'b0;
			end
			valid_out <= valid[sel_index] | (set_valid && same_set);
			dirty_out <= same_set && (set_dirty || clear_dirty) ? set_dirty : dirty[sel_index];
		end
	end

endmodule

`default_nettype wire

// File: dcache/dcache_dp.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_dp (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dcache_pkg::word_t      mem_address,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  dcache_pkg::line_t      mem_wdata256,
	input  dcache_pkg::line_mask_t mem_byte_enable256,
	input  dcache_pkg::line_t      pmem_rdata,
	output dcache_pkg::line_t      mem_rdata256,
	output dcache_pkg::line_t      pmem_wdata,
	output dcache_pkg::word_t      pmem_address,
	output dcache_pkg::word_t      pipe_address,
	dcache_ctrl_if.dp              ctrl
);

	dcache_pkg::index_t              index;
	dcache_pkg::index_t              pipe_index;
	dcache_pkg::tag_t                pipe_tag;
	dcache_pkg::line_t               pipe_wdata;
	dcache_pkg::line_mask_t          pipe_mask;
	logic                            pipe_read;
	logic                            pipe_write;
	logic                            advance;
	dcache_pkg::line_t               latched_rdata;
	dcache_pkg::line_t               datain;
	dcache_pkg::line_t               data_out [2];
	dcache_pkg::line_mask_t          write_en [2];
	dcache_pkg::tag_t                tag_out [2];
	logic [1:0]                      valid_out;
	logic [1:0]                      dirty_out;
	logic [1:0]                      way_hit;
	logic [dcache_pkg::num_sets-1:0] lru;
	logic                            victim;

	assign index      = mem_address[dcache_pkg::s_offset +: dcache_pkg::s_index];
	assign pipe_index = pipe_address[dcache_pkg::s_offset +: dcache_pkg::s_index];
	assign pipe_tag   = pipe_address[dcache_pkg::s_offset + dcache_pkg::s_index +: dcache_pkg::s_tag];
	assign advance    = ctrl.load_pipe | ~(pipe_read | pipe_write); // an empty stage 2 always fills

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipe_read  <= 1'b0;
			pipe_write <= 1'b0;
		end else if (advance) begin
			pipe_read  <= mem_read;
			pipe_write <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			pipe_address <= mem_address;
			pipe_wdata   <= mem_wdata256;
			pipe_mask    <= mem_byte_enable256;
		end
		if (ctrl.latch_rdata) begin
			latched_rdata <= pmem_rdata;
		end
	end

	for (genvar w = 0; w < 2; w++) begin : g_way
		dcache_data_array u_data (
			.clk     (clk),
			.write_en(write_en[w]),
			.rindex  (index),
			.windex  (pipe_index),
			.read    (advance),
			.datain  (datain),
			.dataout (data_out[w])
		);

		dcache_tag_array u_tag (
			.clk        (clk),
			.rst_n      (rst_n),
			.read       (advance),
			.rindex     (index),
			.windex     (pipe_index),
			.load_tag   (ctrl.load_tag[w]),
			.set_valid  (ctrl.set_valid & ctrl.load_tag[w]),
			.set_dirty  (ctrl.set_dirty[w]),
			.clear_dirty(ctrl.clear_dirty[w]),
			.tag_in     (pipe_tag),
			.tag_out    (tag_out[w]),
			.valid_out  (valid_out[w]),
			.dirty_out  (dirty_out[w])
		);

		assign way_hit[w]  = valid_out[w] && tag_out[w] == pipe_tag && !ctrl.use_latched;
		assign write_en[w] = !ctrl.load_data[w] ? '0 : (ctrl.use_latched ? '1 : pipe_mask);
	end

	assign victim            = lru[pipe_index];
	assign ctrl.hit          = |way_hit;
	assign ctrl.way0_hit     = way_hit[0];
	assign ctrl.lru_way      = victim;
	assign ctrl.victim_dirty = dirty_out[victim] & valid_out[victim];
	assign ctrl.pipe_read    = pipe_read;
	assign ctrl.pipe_write   = pipe_write;

	assign datain       = ctrl.use_latched ? latched_rdata : pipe_wdata; // fill line or merged word
	assign mem_rdata256 = ctrl.use_latched ? latched_rdata : data_out[way_hit[1]];
	assign pmem_wdata   = data_out[victim];
	assign pmem_address = ctrl.wb_addr ? {tag_out[victim], pipe_index, {dcache_pkg::s_offset{1'b0}}}
		: {pipe_tag, pipe_index, {dcache_pkg::s_offset{1'b0}}};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lru <= '0;
		end else if (ctrl.load_lru) begin
			lru[pipe_index] <= way_hit[0]; // the way that was not touched becomes the victim
		end
	end

endmodule

`default_nettype wire

// File: dcache/dcache_control.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_control (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       pipe_read,
	input  logic       pipe_write,
	input  logic       pmem_resp,
	output logic       mem_resp,
	output logic       pmem_read,
	output logic       pmem_write,
	dcache_ctrl_if.ctrl ctrl
);

	dcache_pkg::ctrl_state_t state;
	dcache_pkg::ctrl_state_t next_state;
	logic                    request;
	logic [1:0]              hit_mask;
	logic [1:0]              victim_mask;

	assign request     = pipe_read | pipe_write;
	assign hit_mask    = {~ctrl.way0_hit, ctrl.way0_hit};
	assign victim_mask = {ctrl.lru_way, ~ctrl.lru_way};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dcache_pkg::s_compare;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state       = state;
		mem_resp         = 1'b0;
		pmem_read        = 1'b0;
		pmem_write       = 1'b0;
		ctrl.load_pipe   = 1'b0;
		ctrl.load_data   = 2'b00;
		ctrl.load_tag    = 2'b00;
		ctrl.set_valid   = 1'b0;
		ctrl.set_dirty   = 2'b00;
		ctrl.clear_dirty = 2'b00;
		ctrl.load_lru    = 1'b0;
		ctrl.latch_rdata = 1'b0;
		ctrl.use_latched = 1'b0;
		ctrl.wb_addr     = 1'b0;

		unique case (state)
			dcache_pkg::s_compare: begin
				if (request && ctrl.hit) begin
					mem_resp       = 1'b1;
					ctrl.load_pipe = 1'b1; // the next request moves up in the same cycle
					ctrl.load_lru  = 1'b1;
					if (pipe_write) begin
						ctrl.load_data = hit_mask;
						ctrl.set_dirty = hit_mask;
					end
				end else if (request) begin
					next_state = ctrl.victim_dirty ? dcache_pkg::s_writeback : dcache_pkg::s_fill;
				end
			end

			dcache_pkg::s_writeback: begin
				pmem_write   = 1'b1;
				ctrl.wb_addr = 1'b1;
				if (pmem_resp) begin
					next_state = dcache_pkg::s_fill;
				end
			end

			dcache_pkg::s_fill: begin
				pmem_read        = 1'b1;
				ctrl.latch_rdata = pmem_resp;
				if (pmem_resp) begin
					next_state = dcache_pkg::s_replay;
				end
			end

			dcache_pkg::s_replay: begin
				// the victim way takes the fill line as a clean, valid entry
				ctrl.use_latched = 1'b1;
				ctrl.load_data   = victim_mask;
				ctrl.load_tag    = victim_mask;
				ctrl.set_valid   = 1'b1;
				ctrl.clear_dirty = victim_mask;
				next_state       = dcache_pkg::s_compare;
			end

			default: begin
				next_state = dcache_pkg::s_compare;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/line_adapter.sv
`timescale 1ns/10ps
`default_nettype none

module line_adapter (
	input  dcache_pkg::word_t      mem_address,
	input  dcache_pkg::word_t      mem_wdata,
	input  logic [3:0]             mem_byte_enable,
	input  dcache_pkg::line_t      line_rdata,
	output dcache_pkg::line_t      mem_wdata256,
	output dcache_pkg::line_mask_t mem_byte_enable256,
	output dcache_pkg::word_t      mem_rdata
);

	logic [dcache_pkg::s_offset-3:0] word_sel; // word position within the line

	assign word_sel = mem_address[dcache_pkg::s_offset-1:2];

	// the word goes to every lane, only the enabled lane gets written
	assign mem_wdata256 = {dcache_pkg::num_words{mem_wdata}};

	assign mem_byte_enable256 = dcache_pkg::line_mask_t'(mem_byte_enable) << (4*word_sel);

	assign mem_rdata = line_rdata[32*word_sel +: 32];

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_read,
	input  logic              mem_write,
	input  dcache_pkg::word_t mem_address,
	input  dcache_pkg::word_t mem_wdata,
	input  logic [3:0]        mem_byte_enable,
	output dcache_pkg::word_t mem_rdata,
	output logic              mem_resp,
	output logic              pmem_read,
	output logic              pmem_write,
	output dcache_pkg::word_t pmem_address,
	output dcache_pkg::line_t pmem_wdata,
	input  dcache_pkg::line_t pmem_rdata,
	input  logic              pmem_resp
);

	dcache_pkg::line_t      mem_wdata256;
	dcache_pkg::line_mask_t mem_byte_enable256;
	dcache_pkg::line_t      mem_rdata256;
	dcache_pkg::word_t      pipe_address;

	dcache_ctrl_if ctrl_if ();

	// write lanes come from the stage-1 request, the read word is picked with the stage-2 address
	line_adapter u_wr_adapter (
		.mem_address       (mem_address),
		.mem_wdata         (mem_wdata),
		.mem_byte_enable   (mem_byte_enable),
		.line_rdata        (mem_rdata256),
		.mem_wdata256      (mem_wdata256),
		.mem_byte_enable256(mem_byte_enable256),
		.mem_rdata         ()
	);

	line_adapter u_rd_adapter (
		.mem_address       (pipe_address),
		.mem_wdata         (mem_wdata),
		.mem_byte_enable   (mem_byte_enable),
		.line_rdata        (mem_rdata256),
		.mem_wdata256      (),
		.mem_byte_enable256(),
		.mem_rdata         (mem_rdata)
	);

	dcache_dp u_dp (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_address       (mem_address),
		.mem_read          (mem_read),
		.mem_write         (mem_write),
		.mem_wdata256      (mem_wdata256),
		.mem_byte_enable256(mem_byte_enable256),
		.pmem_rdata        (pmem_rdata),
		.mem_rdata256      (mem_rdata256),
		.pmem_wdata        (pmem_wdata),
		.pmem_address      (pmem_address),
		.pipe_address      (pipe_address),
		.ctrl              (ctrl_if.dp)
	);

	dcache_control u_control (
		.clk       (clk),
		.rst_n     (rst_n),
		.pipe_read (ctrl_if.pipe_read),
		.pipe_write(ctrl_if.pipe_write),
		.pmem_resp (pmem_resp),
		.mem_resp  (mem_resp),
		.pmem_read (pmem_read),
		.pmem_write(pmem_write),
		.ctrl      (ctrl_if.ctrl)
	);

endmodule

`default_nettype wire

// File: testbench/dcache_props.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_props (
	input logic              clk,
	input logic              rst_n,
	input logic              mem_read,
	input logic              mem_write,
	input dcache_pkg::word_t mem_address,
	input dcache_pkg::word_t mem_wdata,
	input logic [3:0]        mem_byte_enable,
	input logic              mem_resp,
	input logic              pmem_read,
	input logic              pmem_write,
	input logic              pmem_resp
);

	logic [69:0] request; // everything the core presents

	assign request = {mem_read, mem_write, mem_address, mem_wdata, mem_byte_enable};

	single_resp: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |=> !(mem_resp && $stable(request)))
		else $error("mem_resp repeated for a held request");

	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_read && !pmem_resp |=> pmem_read)
		else $error("pmem_read dropped before pmem_resp");

	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_write && !pmem_resp |=> pmem_write)
		else $error("pmem_write dropped before pmem_resp");

	// a fill is always followed by the replay cycle
	read_dropped: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_read && pmem_resp |=> !pmem_read)
		else $error("pmem_read still high after pmem_resp");

endmodule

bind dcache_top dcache_props u_props (
	.clk            (clk),
	.rst_n          (rst_n),
	.mem_read       (mem_read),
	.mem_write      (mem_write),
	.mem_address    (mem_address),
	.mem_wdata      (mem_wdata),
	.mem_byte_enable(mem_byte_enable),
	.mem_resp       (mem_resp),
	.pmem_read      (pmem_read),
	.pmem_write     (pmem_write),
	.pmem_resp      (pmem_resp)
);

`default_nettype wire

// File: testbench/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

	localparam int mem_lines      = 64;
	localparam int timeout_cycles = 200;
	localparam int num_random     = 400;

	typedef struct packed {
		logic              check; // reads are compared, writes only keep the order
		dcache_pkg::word_t addr;
		dcache_pkg::word_t data;
	} expect_t;

	logic              clk;
	logic              rst_n;
	logic              mem_read;
	logic              mem_write;
	dcache_pkg::word_t mem_address;
	dcache_pkg::word_t mem_wdata;
	logic [3:0]        mem_byte_enable;
	dcache_pkg::word_t mem_rdata;
	logic              mem_resp;
	logic              pmem_read;
	logic              pmem_write;
	dcache_pkg::word_t pmem_address;
	dcache_pkg::line_t pmem_wdata;
	dcache_pkg::line_t pmem_rdata;
	logic              pmem_resp;

	integer            seed;
	integer            lat_seed;
	logic [7:0]        shadow [mem_lines*32]; // byte image of what the core should see
	dcache_pkg::line_t memory [mem_lines];
	expect_t           exp_q [$];
	int                value_errors;
	int                protocol_errors;
	int                timeouts;
	int                fills;
	int                writebacks;
	int                req_fills;
	int                req_wbs;
	dcache_pkg::word_t last_fill;
	dcache_pkg::word_t last_wb;
	int                wait_cnt;
	logic              busy;

	dcache_top DUT (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic dcache_pkg::word_t initial_word(input dcache_pkg::word_t addr);
		return (addr * 32'h9e3779b1) ^ 32'h5ac30f96;
	endfunction

	function automatic dcache_pkg::word_t expected_word(input dcache_pkg::word_t addr);
		int base;
		base = 4 * int'(addr[10:2]);
		return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
	endfunction

	function automatic dcache_pkg::line_t shadow_line(input dcache_pkg::word_t addr);
		dcache_pkg::line_t line;
		for (int i = 0; i < 32; i++) begin
			line[8*i +: 8] = shadow[32*int'(addr[10:5]) + i];
		end
		return line;
	endfunction

	task automatic respond();
		int l;
		l = int'(pmem_address[10:5]);
		if (pmem_write) begin
			writebacks++;
			last_wb = pmem_address;
			assert (pmem_wdata == shadow_line(pmem_address)) else begin
				value_errors++;
				$display("CHECK FAILED pmem_wdata at %h got %h expected %h",
					pmem_address, pmem_wdata, shadow_line(pmem_address));
			end
			memory[l] = pmem_wdata;
		end else begin
			fills++;
			last_fill  = pmem_address;
			pmem_rdata = memory[l];
		end
		pmem_resp = 1'b1;
	endtask

	// physical memory, answers each strobe after 2 to 6 cycles
	initial begin
		pmem_resp  = 1'b0;
		pmem_rdata = '0;
		busy       = 1'b0;
		wait_cnt   = 0;
		forever begin
			@(posedge clk);
			#1;
			pmem_resp = 1'b0;
			if (busy && wait_cnt > 0) begin
				wait_cnt--;
			end else if (busy) begin
				busy = 1'b0;
				respond();
			end else if (pmem_read || pmem_write) begin
				busy     = 1'b1;
				wait_cnt = 1 + ({$random(lat_seed)} % 5);
			end
		end
	end

	always @(negedge clk) begin
		expect_t e;
		if (rst_n && mem_resp) begin
			assert (exp_q.size() != 0) else begin
				protocol_errors++;
				$display("mem_resp arrived with no request outstanding");
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (!e.check || mem_rdata == e.data) else begin
					value_errors++;
					$display("CHECK FAILED mem_rdata at %h got %h expected %h",
						e.addr, mem_rdata, e.data);
				end
			end
		end
	end

	// called just after a rising edge, returns in the response cycle with the request dropped
	task automatic access(input logic wr, input dcache_pkg::word_t addr,
		input dcache_pkg::word_t data, input logic [3:0] be, input logic gap);
		expect_t e;
		int      n;
		int      f0;
		int      w0;
		f0 = fills;
		w0 = writebacks;
		if (wr) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i]) begin
					shadow[4*int'(addr[10:2]) + i] = data[8*i +: 8];
				end
			end
		end
		e.check = !wr;
		e.addr  = addr;
		e.data  = expected_word(addr);
		exp_q.push_back(e);
		mem_read        = !wr;
		mem_write       = wr;
		mem_address     = addr;
		mem_wdata       = data;
		mem_byte_enable = be;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!mem_resp && n < timeout_cycles);
		assert (mem_resp) else begin
			timeouts++;
			$display("no mem_resp within %0d cycles for the access at %h", timeout_cycles, addr);
		end
		mem_read  = 1'b0;
		mem_write = 1'b0;
		req_fills = fills - f0;
		req_wbs   = writebacks - w0;
		if (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_traffic(input string what, input int exp_fills, input int exp_wbs);
		assert (req_fills == exp_fills && req_wbs == exp_wbs) else begin
			value_errors++;
			$display("CHECK FAILED pmem_read/pmem_write count (%s) got %h/%h expected %h/%h",
				what, req_fills, req_wbs, exp_fills, exp_wbs);
		end
	endtask

	task automatic check_addr(input string what, input dcache_pkg::word_t got,
		input dcache_pkg::word_t exp);
		assert (got == exp) else begin
			value_errors++;
			$display("CHECK FAILED pmem_address (%s) got %h expected %h", what, got, exp);
		end
	endtask

	initial begin
		dcache_pkg::word_t rnd;
		dcache_pkg::word_t addr;
		dcache_pkg::word_t prev;
		dcache_pkg::word_t w;
		seed            = 32'h09c6dab1;
		lat_seed        = seed;
		rst_n           = 1'b0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		mem_address     = '0;
		mem_wdata       = '0;
		mem_byte_enable = 4'h0;
		for (int a = 0; a < mem_lines*32; a++) begin
			w         = initial_word(dcache_pkg::word_t'(a & ~3));
			shadow[a] = w[8*(a%4) +: 8];
		end
		for (int l = 0; l < mem_lines; l++) begin
			for (int k = 0; k < 8; k++) begin
				memory[l][32*k +: 32] = initial_word(dcache_pkg::word_t'(32*l + 4*k));
			end
		end
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		access(1'b0, 32'h008, '0, 4'h0, 1'b1);
		check_traffic("cold read", 1, 0);
		access(1'b0, 32'h008, '0, 4'h0, 1'b1);
		check_traffic("read hit", 0, 0);
		access(1'b1, 32'h004, 32'hdeadbeef, 4'b1010, 1'b1);
		access(1'b0, 32'h004, '0, 4'h0, 1'b1);
		check_traffic("read after write", 0, 0);

		// set 1 holds tags 0 and 1, tag 2 then pushes out whichever is older
		access(1'b0, 32'h020, '0, 4'h0, 1'b1);
		access(1'b0, 32'h120, '0, 4'h0, 1'b1);
		access(1'b0, 32'h02c, '0, 4'h0, 1'b1);
		check_traffic("first tag resident", 0, 0);
		access(1'b0, 32'h13c, '0, 4'h0, 1'b1);
		check_traffic("second tag resident", 0, 0);
		access(1'b0, 32'h220, '0, 4'h0, 1'b1);
		check_traffic("third tag", 1, 0);
		check_addr("third tag fill", last_fill, 32'h220);
		access(1'b0, 32'h124, '0, 4'h0, 1'b1);
		check_traffic("recent tag kept", 0, 0);
		access(1'b0, 32'h020, '0, 4'h0, 1'b1);
		check_traffic("older tag evicted", 1, 0);
		check_addr("refill of evicted tag", last_fill, 32'h020);

		// a dirty victim goes back to memory, a clean one does not
		access(1'b1, 32'h024, 32'h12345678, 4'b0110, 1'b1);
		access(1'b0, 32'h128, '0, 4'h0, 1'b1);
		access(1'b0, 32'h228, '0, 4'h0, 1'b1);
		check_traffic("dirty victim", 1, 1);
		check_addr("write-back", last_wb, 32'h020);
		access(1'b0, 32'h024, '0, 4'h0, 1'b1);
		check_traffic("clean victim", 1, 0);

		prev = '1;
		for (int k = 0; k < num_random; k++) begin
			rnd  = $random(seed);
			addr = dcache_pkg::word_t'(32 * ({$random(seed)} % 24) + 4 * int'(rnd[7:5]));
			if (addr == prev) begin
				addr ^= 32'h4; // the same request twice in a row would look like a held one
			end
			access(rnd[4], addr, $random(seed), (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0], 1'b0);
			prev = addr;
		end

		@(posedge clk);
		#1;
		assert (exp_q.size() == 0) else begin
			protocol_errors++;
			$display("%0d responses never arrived", exp_q.size());
		end
		$display("errors: %0d wrong values, %0d protocol, %0d timeouts",
			value_errors, protocol_errors, timeouts);
		if (value_errors + protocol_errors + timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache_top.f
common/dcache_pkg.sv
common/dcache_ctrl_if.sv
dcache/dcache_data_array.sv
dcache/dcache_tag_array.sv
dcache/dcache_dp.sv
dcache/dcache_control.sv
design/line_adapter.sv
design/dcache_top.sv
testbench/dcache_props.sv
testbench/dcache_tb.sv

// File: Makefile
TOP := dcache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dcache_top.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module dcache_top -f dcache_top.f

clean:
	rm -rf obj_dir
